//--- Bender.yml
package:
  name: a23_cp15

sources:
  - verilog/a23_cp15_pkg.sv
  - verilog/a23_cache_pkg.sv
  - verilog/a23_flush_if.sv
  - verilog/a23_cp15_regs.sv
  - verilog/a23_fault_capture.sv
  - verilog/a23_flush_ctrl.sv
  - verilog/a23_flush_counter.sv
  - verilog/a23_cp15_top.sv
  - target: test
    files:
      - tests/tb_a23_cp15.sv

//--- sim.f
verilog/a23_cp15_pkg.sv
verilog/a23_cache_pkg.sv
verilog/a23_flush_if.sv
verilog/a23_cp15_regs.sv
verilog/a23_fault_capture.sv
verilog/a23_flush_ctrl.sv
verilog/a23_flush_counter.sv
verilog/a23_cp15_top.sv
tests/tb_a23_cp15.sv

//--- tests/a23_cp15_trace.txt
// kind instr wdata iabt_status iabt_address dabt_status dabt_address expected
// kinds: 1 op (o_undef), 2 read, 3 cache enable, 4 cacheable area, 5 fault, 6 flush (cycles)
// reset values
2 EE120F10 00000000 00 00000000 00 00000000 00000000
4 00000000 00000000 00 00000000 00 00000000 00000000
// cache control keeps bit 0 only
1 EE020F10 FFFFFFFF 00 00000000 00 00000000 00000000
3 00000000 00000000 00 00000000 00 00000000 00000001
2 EE120F10 00000000 00 00000000 00 00000000 00000001
// cacheable area
1 EE030F10 8000F000 00 00000000 00 00000000 00000000
4 00000000 00000000 00 00000000 00 00000000 8000F000
2 EE130F10 00000000 00 00000000 00 00000000 8000F000
// ID word is read only, unmapped registers read zero
2 EE100F10 00000000 00 00000000 00 00000000 41560200
1 EE000F10 12345678 00 00000000 00 00000000 00000000
2 EE100F10 00000000 00 00000000 00 00000000 41560200
1 EE050F10 DEADBEEF 00 00000000 00 00000000 00000000
2 EE150F10 00000000 00 00000000 00 00000000 00000000
// CDP and a foreign coprocessor are undefined and change nothing
1 EE020F00 00000000 00 00000000 00 00000000 00000001
3 00000000 00000000 00 00000000 00 00000000 00000001
1 EE030E10 00000000 00 00000000 00 00000000 00000001
4 00000000 00000000 00 00000000 00 00000000 8000F000
// prefetch abort, data abort, then both in one cycle
5 00000000 00000001 05 00001000 00 00000000 00000000
2 EE160F10 00000000 00 00000000 00 00000000 00000005
2 EE170F10 00000000 00 00000000 00 00000000 00001000
5 00000000 00000002 00 00000000 0D 00002004 00000000
2 EE160F10 00000000 00 00000000 00 00000000 0000000D
2 EE170F10 00000000 00 00000000 00 00000000 00002004
5 00000000 00000003 07 00003000 0F 00004008 00000000
2 EE160F10 00000000 00 00000000 00 00000000 0000000F
2 EE170F10 00000000 00 00000000 00 00000000 00004008
// flush, then a flush with a second write halfway through
6 EE010F10 00000000 00 00000000 00 00000000 00000010
6 EE010F10 00000001 00 00000000 00 00000000 00000010
3 00000000 00000000 00 00000000 00 00000000 00000001

//--- tests/tb_a23_cp15.sv
/*
 * Trace-driven testbench for the cp15 top level. Replays the entries of
 * tests/a23_cp15_trace.txt under pseudo-random fetch stall.
 */

`timescale 1ns/1ps

module tb_a23_cp15;

    localparam int ENTRY_WORDS = 8;
    localparam int MAX_ENTRIES = 64;
    localparam int LINES       = a23_cache_pkg::CACHE_LINES;

    logic                                    i_clk;
    logic                                    i_rst;
    logic                                    i_copro_valid;
    a23_cp15_pkg::copro_instr_t              i_copro_instr;
    logic [a23_cp15_pkg::WORD_W-1:0]         i_copro_write_data;
    logic                                    i_fetch_stall;
    logic                                    i_iabt_trigger;
    logic                                    i_dabt_trigger;
    logic [a23_cp15_pkg::FAULT_STATUS_W-1:0] i_iabt_status;
    logic [a23_cp15_pkg::FAULT_STATUS_W-1:0] i_dabt_status;
    logic [a23_cp15_pkg::WORD_W-1:0]         i_iabt_address;
    logic [a23_cp15_pkg::WORD_W-1:0]         i_dabt_address;
    logic [a23_cp15_pkg::WORD_W-1:0]         o_copro_read_data;
    logic                                    o_undef;
    logic                                    o_cache_enable;
    logic [a23_cp15_pkg::WORD_W-1:0]         o_cacheable_area;
    logic                                    o_cache_flush;
    logic [a23_cache_pkg::LINE_W-1:0]        o_flush_line;

    // one entry: kind, instr, wdata, iabt status/address, dabt status/address, expected
    logic [31:0] trace_mem [0:MAX_ENTRIES*ENTRY_WORDS-1];
    logic [31:0] ent [0:ENTRY_WORDS-1];
    logic [15:0] lfsr;
    logic        stall_bit;
    logic        second_pending;
    bit          trace_loaded = 1'b0;
    int          trace_count  = 0;
    int          checks       = 0;
    int          errors       = 0;
    int          entry_errors;
    int          flush_count;

    a23_cp15_top i_dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // open a new cycle with a fresh stall bit
    task automatic tick();
        @(posedge i_clk);
        lfsr = lfsr_step(lfsr);
        stall_bit = lfsr[0];
        i_fetch_stall <= stall_bit;
    endtask

    // inputs already driven are held until a cycle without stall has passed
    task automatic wait_accept();
        while (stall_bit) begin
            tick();
        end
        tick();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic issue_op(input logic [31:0] instr, input logic [31:0] wdata);
        tick();
        i_copro_valid      <= 1'b1;
        i_copro_instr      <= instr;
        i_copro_write_data <= wdata;
        wait_accept();
        i_copro_valid <= 1'b0;
        @(negedge i_clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // flush walk, lines must come out in order on non-stalled cycles
    ////////////////////////////////////////////////////////////////////////////
    task automatic run_flush(input logic [31:0] instr, input logic second);
        flush_count    = 0;
        second_pending = 1'b0;
        issue_op(instr, 32'h0);
        check_value("o_cache_flush", o_cache_flush, 32'h1);
        while (o_cache_flush) begin
            if (!i_fetch_stall) begin
                check_value("o_flush_line", o_flush_line, flush_count);
                // a repeated write is taken in this cycle
                if (i_copro_valid) begin
                    second_pending = 1'b0;
                end
                flush_count++;
                if (second && flush_count == LINES / 2) begin
                    second_pending = 1'b1;
                end
            end
            tick();
            i_copro_valid <= second_pending;
            @(negedge i_clk);
        end
    endtask

    task automatic apply_fault();
        tick();
        i_iabt_trigger <= ent[2][0];
        i_dabt_trigger <= ent[2][1];
        i_iabt_status  <= ent[3][a23_cp15_pkg::FAULT_STATUS_W-1:0];
        i_iabt_address <= ent[4];
        i_dabt_status  <= ent[5][a23_cp15_pkg::FAULT_STATUS_W-1:0];
        i_dabt_address <= ent[6];
        wait_accept();
        i_iabt_trigger <= 1'b0;
        i_dabt_trigger <= 1'b0;
        @(negedge i_clk);
    endtask

    initial begin
        i_rst              = 1'b1;
        i_copro_valid      = 1'b0;
        i_copro_instr      = '0;
        i_copro_write_data = '0;
        i_fetch_stall      = 1'b0;
        i_iabt_trigger     = 1'b0;
        i_dabt_trigger     = 1'b0;
        i_iabt_status      = '0;
        i_dabt_status      = '0;
        i_iabt_address     = '0;
        i_dabt_address     = '0;
        stall_bit          = 1'b0;
        lfsr               = 16'd76;
        $readmemh("tests/a23_cp15_trace.txt", trace_mem);
        while (trace_count < MAX_ENTRIES && !$isunknown(trace_mem[trace_count*ENTRY_WORDS])
               && trace_mem[trace_count*ENTRY_WORDS] != 0) begin
            trace_count++;
        end
        trace_loaded = 1'b1;
        if (trace_count == 0) begin
            errors++;
            $display("No entries could be read from the trace file");
        end
        repeat (2) @(posedge i_clk);
        i_rst <= 1'b0;
        for (int e = 0; e < trace_count; e++) begin
            for (int w = 0; w < ENTRY_WORDS; w++) begin
                ent[w] = trace_mem[e*ENTRY_WORDS + w];
            end
            entry_errors = errors;
            case (ent[0])
                1: begin
                    issue_op(ent[1], ent[2]);
                    check_value("o_undef", o_undef, ent[7]);
                end
                2: begin
                    issue_op(ent[1], ent[2]);
                    check_value("o_copro_read_data", o_copro_read_data, ent[7]);
                end
                3: begin
                    tick();
                    @(negedge i_clk);
                    check_value("o_cache_enable", o_cache_enable, ent[7]);
                end
                4: begin
                    tick();
                    @(negedge i_clk);
                    check_value("o_cacheable_area", o_cacheable_area, ent[7]);
                end
                5: apply_fault();
                6: begin
                    run_flush(ent[1], ent[2][0]);
                    check_value("flush cycles", flush_count, ent[7]);
                end
                default: begin
                    errors++;
                    $display("Entry %0d has an unknown kind %0d", e, ent[0]);
                end
            endcase
            $display("entry %0d kind %0d %s", e, ent[0],
                     (errors == entry_errors) ? "ok" : "failed");
        end
        $display("%0d entries, %0d checks, %0d errors", trace_count, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog, scaled by the worst case of a stalled flush per entry
    initial begin
        wait (trace_loaded);
        repeat (trace_count * (LINES * 8 + 10)) @(posedge i_clk);
        $display("Timeout, the trace did not finish within %0d cycles",
                 trace_count * (LINES * 8 + 10));
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- verilog/a23_cache_pkg.sv
/*
 * Cache geometry seen by the cp15 flush sequence: line count and the
 * width of the line index walked during a flush.
 */

package a23_cache_pkg;

    // number of cache lines
    localparam int CACHE_LINES = 16;

    // width of the line index
    localparam int LINE_W = 4;

endpackage

//--- verilog/a23_cp15_pkg.sv
/*
 * System control coprocessor definitions: register map, coprocessor
 * number, ID word, fault widths and the coprocessor instruction word.
 * Referenced by scoped name from the cp15 RTL and its testbench.
 */

package a23_cp15_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int WORD_W         = 32;
    localparam int FAULT_STATUS_W = 8;
    localparam int CRN_W          = 4;

    // coprocessor number answered by this unit
    localparam logic [3:0] CP15_NUM = 4'd15;

    // read-only identification word
    localparam logic [WORD_W-1:0] CP15_ID = 32'h4156_0200;

    ////////////////////////////////////////////////////////////////////////////
    // register map
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [CRN_W-1:0] CRN_ID           = 4'd0;
    localparam logic [CRN_W-1:0] CRN_FLUSH        = 4'd1;
    localparam logic [CRN_W-1:0] CRN_CACHE_CTRL   = 4'd2;
    localparam logic [CRN_W-1:0] CRN_CACHEABLE    = 4'd3;
    localparam logic [CRN_W-1:0] CRN_FAULT_STATUS = 4'd6;
    localparam logic [CRN_W-1:0] CRN_FAULT_ADDR   = 4'd7;

    ////////////////////////////////////////////////////////////////////////////
    // instruction word
    ////////////////////////////////////////////////////////////////////////////

    // register transfer, MCR when load is low and MRC when high
    typedef struct packed {
        logic [3:0]       cond;
        logic [3:0]       fixed;
        logic [2:0]       opcode1;
        logic             load;
        logic [CRN_W-1:0] crn;
        logic [3:0]       rd;
        logic [3:0]       cp_num;
        logic [2:0]       opcode2;
        logic             xfer;
        logic [3:0]       crm;
    } copro_xfer_t;

    // data operation, opcode1 takes over the load bit
    typedef struct packed {
        logic [3:0]       cond;
        logic [3:0]       fixed;
        logic [3:0]       opcode1;
        logic [CRN_W-1:0] crn;
        logic [3:0]       rd;
        logic [3:0]       cp_num;
        logic [2:0]       opcode2;
        logic             xfer;
        logic [3:0]       crm;
    } copro_cdp_t;

    // bit 4 selects the view: 1 for a transfer, 0 for a data operation
    typedef union packed {
        copro_xfer_t xfer;
        copro_cdp_t  cdp;
    } copro_instr_t;

endpackage

//--- verilog/a23_cp15_regs.sv
/*
 * cp15 register file. Decodes MCR/MRC, holds the cache control and
 * cacheable area registers, returns readback one cycle after a read,
 * flags undefined operations and requests a cache flush.
 */

`timescale 1ns/1ps

module a23_cp15_regs (
    input  logic                                    i_clk,
    input  logic                                    i_rst,
    input  logic                                    i_copro_valid,
    input  a23_cp15_pkg::copro_instr_t              i_copro_instr,
    input  logic [a23_cp15_pkg::WORD_W-1:0]         i_copro_write_data,
    input  logic                                    i_fetch_stall,
    input  logic [a23_cp15_pkg::FAULT_STATUS_W-1:0] i_fault_status,
    input  logic [a23_cp15_pkg::WORD_W-1:0]         i_fault_address,
    output logic [a23_cp15_pkg::WORD_W-1:0]         o_copro_read_data,
    output logic                                    o_undef,
    output logic                                    o_cache_enable,
    output logic [a23_cp15_pkg::WORD_W-1:0]         o_cacheable_area,
    output logic                                    o_flush_start
);

    logic                                accept;
    logic                                cdp_op;
    logic                                foreign_op;
    logic                                undef_op;
    logic                                write_op;
    logic                                read_op;
    logic [a23_cp15_pkg::CRN_W-1:0]      crn;
    logic [a23_cp15_pkg::WORD_W-1:0]     read_mux;

    ////////////////////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////////////////////
    assign accept = i_copro_valid && !i_fetch_stall;

    // bit 4 low means CDP, which this unit never executes
    assign cdp_op     = !i_copro_instr.cdp.xfer;
    assign foreign_op = i_copro_instr.xfer.cp_num != a23_cp15_pkg::CP15_NUM;
    assign undef_op   = accept && (cdp_op || foreign_op);

    assign write_op = accept && !undef_op && !i_copro_instr.xfer.load;
    assign read_op  = accept && !undef_op && i_copro_instr.xfer.load;
    assign crn      = i_copro_instr.xfer.crn;

    // one-cycle request taken only from an accepted write
    assign o_flush_start = write_op && (crn == a23_cp15_pkg::CRN_FLUSH);

    ////////////////////////////////////////////////////////////////////////////
    // control registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_cache_enable   <= 1'b0;
            o_cacheable_area <= '0;
        end else if (write_op) begin
            case (crn)
                a23_cp15_pkg::CRN_CACHE_CTRL: o_cache_enable <= i_copro_write_data[0];
                a23_cp15_pkg::CRN_CACHEABLE:  o_cacheable_area <= i_copro_write_data;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // readback
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (crn)
            a23_cp15_pkg::CRN_ID:
                read_mux = a23_cp15_pkg::CP15_ID;
            a23_cp15_pkg::CRN_CACHE_CTRL:
                read_mux = {{(a23_cp15_pkg::WORD_W-1){1'b0}}, o_cache_enable};
            a23_cp15_pkg::CRN_CACHEABLE:
                read_mux = o_cacheable_area;
            a23_cp15_pkg::CRN_FAULT_STATUS:
                read_mux = {{(a23_cp15_pkg::WORD_W-a23_cp15_pkg::FAULT_STATUS_W){1'b0}},
                            i_fault_status};
            a23_cp15_pkg::CRN_FAULT_ADDR:
                read_mux = i_fault_address;
            default:
                read_mux = '0;
        endcase
    end

    // read data stays until the next accepted read
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_copro_read_data <= '0;
        end else if (read_op) begin
            o_copro_read_data <= read_mux;
        end
    end

    // undefined strobe lags the offending operation by one cycle
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_undef <= 1'b0;
        end else begin
            o_undef <= undef_op;
        end
    end

    // a flush request never shares a cycle with the undefined strobe
    a_flush_not_undef: assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_flush_start && o_undef));

endmodule

//--- verilog/a23_cp15_top.sv
/*
 * System control coprocessor top level. Connects the register file,
 * fault capture, flush FSM and line counter to plain ports.
 */

`timescale 1ns/1ps

module a23_cp15_top (
    input  logic                                    i_clk,
    input  logic                                    i_rst,
    input  logic                                    i_copro_valid,
    input  a23_cp15_pkg::copro_instr_t              i_copro_instr,
    input  logic [a23_cp15_pkg::WORD_W-1:0]         i_copro_write_data,
    input  logic                                    i_fetch_stall,
    input  logic                                    i_iabt_trigger,
    input  logic                                    i_dabt_trigger,
    input  logic [a23_cp15_pkg::FAULT_STATUS_W-1:0] i_iabt_status,
    input  logic [a23_cp15_pkg::FAULT_STATUS_W-1:0] i_dabt_status,
    input  logic [a23_cp15_pkg::WORD_W-1:0]         i_iabt_address,
    input  logic [a23_cp15_pkg::WORD_W-1:0]         i_dabt_address,
    output logic [a23_cp15_pkg::WORD_W-1:0]         o_copro_read_data,
    output logic                                    o_undef,
    output logic                                    o_cache_enable,
    output logic [a23_cp15_pkg::WORD_W-1:0]         o_cacheable_area,
    output logic                                    o_cache_flush,
    output logic [a23_cache_pkg::LINE_W-1:0]        o_flush_line
);

    logic [a23_cp15_pkg::FAULT_STATUS_W-1:0] fault_status;
    logic [a23_cp15_pkg::WORD_W-1:0]         fault_address;
    logic                                    flush_start;

    a23_flush_if u_flush_if ();

    a23_cp15_regs u_regs (
        .i_clk              ( i_clk              ),
        .i_rst              ( i_rst              ),
        .i_copro_valid      ( i_copro_valid      ),
        .i_copro_instr      ( i_copro_instr      ),
        .i_copro_write_data ( i_copro_write_data ),
        .i_fetch_stall      ( i_fetch_stall      ),
        .i_fault_status     ( fault_status       ),
        .i_fault_address    ( fault_address      ),
        .o_copro_read_data  ( o_copro_read_data  ),
        .o_undef            ( o_undef            ),
        .o_cache_enable     ( o_cache_enable     ),
        .o_cacheable_area   ( o_cacheable_area   ),
        .o_flush_start      ( flush_start        )
    );

    a23_fault_capture u_fault_capture (
        .i_clk              ( i_clk              ),
        .i_rst              ( i_rst              ),
        .i_fetch_stall      ( i_fetch_stall      ),
        .i_iabt_trigger     ( i_iabt_trigger     ),
        .i_iabt_status      ( i_iabt_status      ),
        .i_iabt_address     ( i_iabt_address     ),
        .i_dabt_trigger     ( i_dabt_trigger     ),
        .i_dabt_status      ( i_dabt_status      ),
        .i_dabt_address     ( i_dabt_address     ),
        .o_fault_status     ( fault_status       ),
        .o_fault_address    ( fault_address      )
    );

    a23_flush_ctrl u_flush_ctrl (
        .i_clk              ( i_clk              ),
        .i_rst              ( i_rst              ),
        .i_fetch_stall      ( i_fetch_stall      ),
        .i_flush_start      ( flush_start        ),
        .flush              ( u_flush_if         ),
        .o_cache_flush      ( o_cache_flush      )
    );

    a23_flush_counter u_flush_counter (
        .i_clk              ( i_clk              ),
        .i_rst              ( i_rst              ),
        .flush              ( u_flush_if         ),
        .o_flush_line       ( o_flush_line       )
    );

endmodule

//--- verilog/a23_fault_capture.sv
/*
 * Fault status and fault address capture. A data abort takes priority
 * over a prefetch abort raised in the same cycle.
 */

`timescale 1ns/1ps

module a23_fault_capture (
    input  logic                                    i_clk,
    input  logic                                    i_rst,
    input  logic                                    i_fetch_stall,
    input  logic                                    i_iabt_trigger,
    input  logic [a23_cp15_pkg::FAULT_STATUS_W-1:0] i_iabt_status,
    input  logic [a23_cp15_pkg::WORD_W-1:0]         i_iabt_address,
    input  logic                                    i_dabt_trigger,
    input  logic [a23_cp15_pkg::FAULT_STATUS_W-1:0] i_dabt_status,
    input  logic [a23_cp15_pkg::WORD_W-1:0]         i_dabt_address,
    output logic [a23_cp15_pkg::FAULT_STATUS_W-1:0] o_fault_status,
    output logic [a23_cp15_pkg::WORD_W-1:0]         o_fault_address
);

    logic                                    fault;
    logic [a23_cp15_pkg::FAULT_STATUS_W-1:0] sel_status;
    logic [a23_cp15_pkg::WORD_W-1:0]         sel_address;

    // data abort wins
    assign fault       = i_dabt_trigger || i_iabt_trigger;
    assign sel_status  = i_dabt_trigger ? i_dabt_status  : i_iabt_status;
    assign sel_address = i_dabt_trigger ? i_dabt_address : i_iabt_address;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_fault_status  <= '0;
            o_fault_address <= '0;
        end else if (fault && !i_fetch_stall) begin
            o_fault_status  <= sel_status;
            o_fault_address <= sel_address;
        end
    end

    // both aborts at once leave the data abort status behind
    a_dabt_priority: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_dabt_trigger && i_iabt_trigger && !i_fetch_stall)
        |=> (o_fault_status == $past(i_dabt_status)));

endmodule

//--- verilog/a23_flush_counter.sv
/*
 * Cache line index for the flush walk. Zeroed on clear, stepped on
 * advance, and wraps to zero after the last line.
 */

`timescale 1ns/1ps

module a23_flush_counter (
    input  logic                             i_clk,
    input  logic                             i_rst,
    a23_flush_if.counter                     flush,
    output logic [a23_cache_pkg::LINE_W-1:0] o_flush_line
);

    logic [a23_cache_pkg::LINE_W-1:0] line;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            line <= '0;
        end else if (flush.clear) begin
            line <= '0;
        end else if (flush.advance) begin
            if (flush.last) begin
                line <= '0;
            end else begin
                line <= line + 1'b1;
            end
        end
    end

    assign flush.line   = line;
    assign flush.last   = line == a23_cache_pkg::LINE_W'(a23_cache_pkg::CACHE_LINES - 1);
    assign o_flush_line = line;

    // stepping past the last line lands back on line zero
    a_wrap_zero: assert property (@(posedge i_clk) disable iff (i_rst)
        (flush.advance && flush.last) |=> (line == '0));

endmodule

//--- verilog/a23_flush_ctrl.sv
/*
 * Cache flush FSM. A start request in IDLE clears the line counter and
 * walks every line once, one line per cycle without fetch stall.
 */

`timescale 1ns/1ps

module a23_flush_ctrl (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_fetch_stall,
    input  logic              i_flush_start,
    a23_flush_if.controller   flush,
    output logic              o_cache_flush
);

    typedef enum logic {
        IDLE,
        FLUSH
    } state_t;

    state_t state;

    ////////////////////////////////////////////////////////////////////////////
    // counter control
    ////////////////////////////////////////////////////////////////////////////

    // a start seen during a flush is dropped
    assign flush.clear   = (state == IDLE) && i_flush_start;
    assign flush.advance = (state == FLUSH) && !i_fetch_stall;
    assign o_cache_flush = (state == FLUSH);

    ////////////////////////////////////////////////////////////////////////////
    // state register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= IDLE;
        end else if (!i_fetch_stall) begin
            case (state)
                IDLE: begin
                    if (i_flush_start) begin
                        state <= FLUSH;
                    end
                end
                FLUSH: begin
                    // last line stepped this cycle
                    if (flush.last) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // no line is walked outside a flush
    a_no_advance_idle: assert property (@(posedge i_clk) disable iff (i_rst)
        (state == IDLE) |-> !flush.advance);

endmodule

//--- verilog/a23_flush_if.sv
/*
 * Link between the flush FSM and the cache line counter.
 * The FSM clears and steps the counter and watches for the last line.
 */

`timescale 1ns/1ps

interface a23_flush_if;

    // driven by the FSM
    logic                             clear;
    logic                             advance;

    // driven by the counter
    logic [a23_cache_pkg::LINE_W-1:0] line;
    logic                             last;

    modport controller (
        output clear,
        output advance,
        input  line,
        input  last
    );

    modport counter (
        input  clear,
        input  advance,
        output line,
        output last
    );

endinterface
